// File: src.f
+incdir+logic
logic/rv32_pkg.sv
logic/rv32_decode.sv
logic/rv32_alu.sv
logic/rv32_exec_regs.sv
logic/rv32_exec_top.sv
testbench/rv32_exec_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := rv32_exec_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/rv32_exec_tb.sv
`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_exec_tb;
    import rv32_pkg::*;

    localparam int NUM_CASES      = 23;
    localparam int TIMEOUT_CYCLES = NUM_CASES * 40 + 200;

    localparam logic [1:0] RESP_OKAY     = 2'b00;
    localparam logic [1:0] RESP_SLVERR   = 2'b10;
    localparam logic [7:0] UNMAPPED_ADDR = 8'h30;

    typedef struct {
        string name;
        word_t pc;
        word_t rs1;
        word_t rs2;
        word_t instr;
        word_t result;
        logic  illegal;
    } test_case_t;

    logic         clk;
    logic         reset;
    axil_wr_req_t wr_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_req_t rd_req;
    axil_rd_rsp_t rd_rsp;

    test_case_t cases [NUM_CASES];
    int         n_cases;
    int         errors;
    int         cycles;

    rv32_exec_top u_rv32_exec_top (
        .clk    (clk),
        .reset  (reset),
        .wr_req (wr_req),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run timed out after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // instruction encodings, rd x3, rs1 x1, rs2 x2
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm12, input logic [2:0] f3);
        return {imm12, 5'd1, f3, 5'd3, 7'b0010011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm20, input logic [6:0] opc);
        return {imm20, 5'd3, opc};
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // handshakes are sampled on the falling edge, where inputs and outputs are settled
    task automatic axi_write(input logic [7:0] addr, input word_t data,
                             input logic [3:0] strb, output logic [1:0] resp);
        logic done;
        @(posedge clk);
        #1;
        wr_req.awvalid = 1'b1;
        wr_req.awaddr  = addr;
        wr_req.wvalid  = 1'b1;
        wr_req.wdata   = data;
        wr_req.wstrb   = strb;
        wr_req.bready  = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = wr_rsp.awready && wr_rsp.wready;
            @(posedge clk);
            #1;
        end
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = wr_rsp.bvalid;
            resp = wr_rsp.bresp;
            @(posedge clk);
            #1;
        end
        // response waits one cycle before it is taken
        wr_req.bready = 1'b1;
        @(posedge clk);
        #1;
        wr_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output word_t data, output logic [1:0] resp);
        logic done;
        @(posedge clk);
        #1;
        rd_req.arvalid = 1'b1;
        rd_req.araddr  = addr;
        rd_req.rready  = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rd_rsp.arready;
            @(posedge clk);
            #1;
        end
        rd_req.arvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rd_rsp.rvalid;
            data = rd_rsp.rdata;
            resp = rd_rsp.rresp;
            @(posedge clk);
            #1;
        end
        // response waits one cycle before it is taken
        rd_req.rready = 1'b1;
        @(posedge clk);
        #1;
        rd_req.rready = 1'b0;
    endtask

    task automatic write_checked(input string name, input logic [7:0] addr, input word_t data,
                                 input logic [3:0] strb, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, strb, resp);
        check_word({name, " bresp"}, word_t'(exp_resp), word_t'(resp));
    endtask

    task automatic read_checked(input string name, input logic [7:0] addr,
                                input word_t exp_data, input logic [1:0] exp_resp);
        word_t      data;
        logic [1:0] resp;
        axi_read(addr, data, resp);
        check_word({name, " rdata"}, exp_data, data);
        check_word({name, " rresp"}, word_t'(exp_resp), word_t'(resp));
    endtask

    task automatic add_case(input string name, input word_t pc, input word_t rs1,
                            input word_t rs2, input word_t instr, input word_t result,
                            input logic illegal);
        cases[n_cases] = '{name, pc, rs1, rs2, instr, result, illegal};
        n_cases++;
    endtask

    // name, pc, rs1, rs2, instr, expected result, expected illegal
    task automatic fill_table();
        add_case("add_carry", 0, 32'hFFFF_FFFF, 32'h2, r_type(7'h00, 3'b000), 32'h1, 0);
        add_case("sub", 0, 32'h5, 32'h7, r_type(7'h20, 3'b000), 32'hFFFF_FFFE, 0);
        add_case("slt_sign", 0, 32'h8000_0000, 32'h1, r_type(7'h00, 3'b010), 32'h1, 0);
        add_case("sltu_sign", 0, 32'h8000_0000, 32'h1, r_type(7'h00, 3'b011), 32'h0, 0);
        add_case("slt_ovf", 0, 32'h7FFF_FFFF, 32'h8000_0000, r_type(7'h00, 3'b010), 32'h0, 0);
        add_case("sltu_rev", 0, 32'h1, 32'h8000_0000, r_type(7'h00, 3'b011), 32'h1, 0);
        add_case("xor", 0, 32'hA5A5_A5A5, 32'h0F0F_0F0F, r_type(7'h00, 3'b100), 32'hAAAA_AAAA, 0);
        add_case("or", 0, 32'hF0F0_0000, 32'h0000_0F0F, r_type(7'h00, 3'b110), 32'hF0F0_0F0F, 0);
        add_case("and", 0, 32'hFF00_FF00, 32'h0FF0_0FF0, r_type(7'h00, 3'b111), 32'h0F00_0F00, 0);
        add_case("sll_31", 0, 32'h3, 32'h1F, r_type(7'h00, 3'b001), 32'h8000_0000, 0);
        add_case("srl_31", 0, 32'h8000_0000, 32'hFFFF_FFFF, r_type(7'h00, 3'b101), 32'h1, 0);
        add_case("sll_low5", 0, 32'h1, 32'h24, r_type(7'h00, 3'b001), 32'h10, 0);
        add_case("sra_neg", 0, 32'h8000_0010, 32'h4, r_type(7'h20, 3'b101), 32'hF800_0001, 0);
        add_case("addi_neg", 0, 32'h10, 32'h0, i_type(12'hFFD, 3'b000), 32'hD, 0);
        add_case("sltiu", 0, 32'h5, 32'h0, i_type(12'hFFF, 3'b011), 32'h1, 0);
        add_case("slti", 0, 32'hFFFF_FFFF, 32'h0, i_type(12'h000, 3'b010), 32'h1, 0);
        add_case("srai", 0, 32'hF000_0000, 32'h0, i_type(12'h408, 3'b101), 32'hFFF0_0000, 0);
        add_case("lui", 0, 32'h0, 32'h0, u_type(20'hABCDE, 7'b0110111), 32'hABCD_E000, 0);
        add_case("auipc", 32'h1000, 32'h0, 32'h0, u_type(20'h12345, 7'b0010111),
                 32'h1234_6000, 0);
        // sw x2, 0(x1)
        add_case("illegal_store", 0, 32'h1, 32'h2, 32'h0020_A023, 32'h0, 1);
        add_case("illegal_xor_f7", 0, 32'h1, 32'h2, r_type(7'h20, 3'b100), 32'h0, 1);
        add_case("illegal_slli_f7", 0, 32'h1, 32'h0, i_type(12'h401, 3'b001), 32'h0, 1);
        add_case("addi_after", 0, 32'h1, 32'h0, i_type(12'h001, 3'b000), 32'h2, 0);
    endtask

    task automatic run_case(input int idx);
        logic [1:0] resp;
        word_t      status;
        status = '0;
        write_checked({cases[idx].name, " pc"}, `RV32_REG_PC, cases[idx].pc, 4'hF, RESP_OKAY);
        write_checked({cases[idx].name, " rs1"}, `RV32_REG_RS1, cases[idx].rs1, 4'hF, RESP_OKAY);
        write_checked({cases[idx].name, " rs2"}, `RV32_REG_RS2, cases[idx].rs2, 4'hF, RESP_OKAY);
        write_checked({cases[idx].name, " instr"}, `RV32_REG_INSTR, cases[idx].instr, 4'hF,
                      RESP_OKAY);
        while (!status[`RV32_STATUS_DONE]) begin
            axi_read(`RV32_REG_STATUS, status, resp);
        end
        check_word({cases[idx].name, " status"}, {30'b0, cases[idx].illegal, 1'b1}, status);
        if (!cases[idx].illegal) begin
            read_checked({cases[idx].name, " result"}, `RV32_REG_RESULT, cases[idx].result,
                         RESP_OKAY);
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        wr_req  = '0;
        rd_req  = '0;
        errors  = 0;
        cycles  = 0;
        n_cases = 0;
        fill_table();
        assert (n_cases == NUM_CASES) else begin
            $display("ERROR: table holds %0d entries instead of %0d", n_cases, NUM_CASES);
            errors++;
        end
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        read_checked("reset pc", `RV32_REG_PC, 32'h0, RESP_OKAY);
        read_checked("reset rs1", `RV32_REG_RS1, 32'h0, RESP_OKAY);
        read_checked("reset rs2", `RV32_REG_RS2, 32'h0, RESP_OKAY);
        read_checked("reset instr", `RV32_REG_INSTR, 32'h0, RESP_OKAY);
        read_checked("reset result", `RV32_REG_RESULT, 32'h0, RESP_OKAY);
        read_checked("reset status", `RV32_REG_STATUS, 32'h0, RESP_OKAY);

        write_checked("readback pc", `RV32_REG_PC, 32'h1122_3344, 4'hF, RESP_OKAY);
        write_checked("readback rs1", `RV32_REG_RS1, 32'h5566_7788, 4'hF, RESP_OKAY);
        write_checked("readback rs2", `RV32_REG_RS2, 32'h99AA_BBCC, 4'hF, RESP_OKAY);
        read_checked("readback pc", `RV32_REG_PC, 32'h1122_3344, RESP_OKAY);
        read_checked("readback rs1", `RV32_REG_RS1, 32'h5566_7788, RESP_OKAY);
        read_checked("readback rs2", `RV32_REG_RS2, 32'h99AA_BBCC, RESP_OKAY);

        // bytes 0 and 2 only
        write_checked("strobe rs1", `RV32_REG_RS1, 32'hDEAD_BEEF, 4'b0101, RESP_OKAY);
        read_checked("strobe rs1", `RV32_REG_RS1, 32'h55AD_77EF, RESP_OKAY);

        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end

        // last entry left 2 in RESULT
        write_checked("write result", `RV32_REG_RESULT, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
        write_checked("write unmapped", UNMAPPED_ADDR, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR);
        read_checked("result kept", `RV32_REG_RESULT, 32'h2, RESP_OKAY);
        read_checked("read unmapped", UNMAPPED_ADDR, 32'h0, RESP_SLVERR);

        $display("simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: logic/rv32_exec_top.sv
`timescale 1ns/100ps

module rv32_exec_top (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32_pkg::axil_wr_req_t wr_req,
    output rv32_pkg::axil_wr_rsp_t wr_rsp,
    input  rv32_pkg::axil_rd_req_t rd_req,
    output rv32_pkg::axil_rd_rsp_t rd_rsp
);
    import rv32_pkg::*;

    word_t     instr;
    logic      issue;
    issue_t    regs_operands;
    issue_t    alu_operands;
    alu_ctrl_t ctrl;
    word_t     imm;
    logic      illegal;
    word_t     result;
    logic      result_valid;

    rv32_exec_regs u_rv32_exec_regs (
        .clk          (clk),
        .reset        (reset),
        .wr_req       (wr_req),
        .wr_rsp       (wr_rsp),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp),
        .instr        (instr),
        .issue        (issue),
        .operands     (regs_operands),
        .illegal      (illegal),
        .result       (result),
        .result_valid (result_valid)
    );

    rv32_decode u_rv32_decode (
        .instr   (instr),
        .ctrl    (ctrl),
        .imm     (imm),
        .illegal (illegal)
    );

    // register block leaves imm empty, the decoder fills it
    always_comb begin
        alu_operands     = regs_operands;
        alu_operands.imm = imm;
    end

    rv32_alu u_rv32_alu (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .ctrl         (ctrl),
        .operands     (alu_operands),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: logic/rv32_exec_regs.sv
`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_exec_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32_pkg::axil_wr_req_t wr_req,
    output rv32_pkg::axil_wr_rsp_t wr_rsp,
    input  rv32_pkg::axil_rd_req_t rd_req,
    output rv32_pkg::axil_rd_rsp_t rd_rsp,
    output rv32_pkg::word_t        instr,
    output logic                   issue,
    output rv32_pkg::issue_t       operands,
    input  logic                   illegal,
    input  rv32_pkg::word_t        result,
    input  logic                   result_valid
);
    import rv32_pkg::*;

    word_t      pc_q;
    word_t      rs1_q;
    word_t      rs2_q;
    word_t      instr_q;
    word_t      result_q;
    logic       issue_q;
    logic       done_q;
    logic       illegal_q;
    logic       illegal_issue_q;
    logic       bvalid_q;
    logic [1:0] bresp_q;
    logic       rvalid_q;
    word_t      rdata_q;
    logic [1:0] rresp_q;
    logic       wr_accept;
    logic       launch;
    logic       rd_accept;
    word_t      rd_word;
    logic       rd_err;

    function automatic word_t apply_strb(input word_t old_val, input word_t new_val,
                                         input logic [`RV32_XLEN/8-1:0] strb);
        word_t res;
        res = old_val;
        for (int i = 0; i < `RV32_XLEN/8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    // address and data are taken together, one write at a time
    assign wr_accept = wr_req.awvalid && wr_req.wvalid && !bvalid_q;
    assign launch    = wr_accept && wr_req.awaddr == `RV32_REG_INSTR;
    assign rd_accept = rd_req.arvalid && !rvalid_q;

    assign wr_rsp = '{awready: wr_accept, wready: wr_accept, bvalid: bvalid_q, bresp: bresp_q};
    assign rd_rsp = '{arready: !rvalid_q, rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

    assign instr    = instr_q;
    assign issue    = issue_q;
    assign operands = '{pc: pc_q, rs1_value: rs1_q, rs2_value: rs2_q, imm: '0};

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            bresp_q  <= AXI_RESP_OKAY;
            pc_q     <= '0;
            rs1_q    <= '0;
            rs2_q    <= '0;
            instr_q  <= '0;
            issue_q  <= 1'b0;
        end else begin
            issue_q <= launch;
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                bresp_q  <= AXI_RESP_OKAY;
                case (wr_req.awaddr)
                    `RV32_REG_PC:    pc_q    <= apply_strb(pc_q, wr_req.wdata, wr_req.wstrb);
                    `RV32_REG_RS1:   rs1_q   <= apply_strb(rs1_q, wr_req.wdata, wr_req.wstrb);
                    `RV32_REG_RS2:   rs2_q   <= apply_strb(rs2_q, wr_req.wdata, wr_req.wstrb);
                    `RV32_REG_INSTR: instr_q <= apply_strb(instr_q, wr_req.wdata, wr_req.wstrb);
                    // read-only and unmapped
                    default:         bresp_q <= AXI_RESP_SLVERR;
                endcase
            end else if (wr_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // done drops at launch, illegal follows the decode sampled at issue
    always_ff @(posedge clk) begin
        if (reset) begin
            result_q        <= '0;
            done_q          <= 1'b0;
            illegal_q       <= 1'b0;
            illegal_issue_q <= 1'b0;
        end else begin
            if (launch) begin
                done_q <= 1'b0;
            end
            if (issue_q) begin
                illegal_issue_q <= illegal;
            end
            if (result_valid) begin
                result_q  <= result;
                done_q    <= 1'b1;
                illegal_q <= illegal_issue_q;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (rd_req.araddr)
            `RV32_REG_PC:     rd_word = pc_q;
            `RV32_REG_RS1:    rd_word = rs1_q;
            `RV32_REG_RS2:    rd_word = rs2_q;
            `RV32_REG_INSTR:  rd_word = instr_q;
            `RV32_REG_RESULT: rd_word = result_q;
            `RV32_REG_STATUS: begin
                rd_word[`RV32_STATUS_DONE]    = done_q;
                rd_word[`RV32_STATUS_ILLEGAL] = illegal_q;
            end
            default:          rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
        end else if (rd_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd_word;
            rresp_q <= rd_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata));

endmodule

// File: logic/rv32_alu.sv
`timescale 1ns/100ps

module rv32_alu (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  rv32_pkg::alu_ctrl_t ctrl,
    input  rv32_pkg::issue_t    operands,
    output rv32_pkg::word_t     result,
    output logic                result_valid
);
    import rv32_pkg::*;

    word_t       src1;
    word_t       src2;
    logic [4:0]  shamt;
    logic        do_sub;
    logic [32:0] add_sub;
    logic [32:0] shift_ext;
    logic [32:0] shift_wide;
    logic        sign;
    logic        ovf;
    logic        lt;
    logic        ltu;
    word_t       alu_out;

    assign src1  = (ctrl.src1_sel == SRC1_PC) ? operands.pc : operands.rs1_value;
    assign src2  = (ctrl.src2_sel == SRC2_IMM) ? operands.imm : operands.rs2_value;
    assign shamt = src2[4:0];

    // compares always subtract, whatever sub_sra says
    assign do_sub  = ctrl.sub_sra || ctrl.op == ALU_SLT || ctrl.op == ALU_SLTU;
    assign add_sub = do_sub ? {1'b0, src1} - {1'b0, src2} : {1'b0, src1} + {1'b0, src2};

    // extra top bit carries the sign for sra, zero for srl
    assign shift_ext  = {ctrl.sub_sra & src1[31], src1};
    assign shift_wide = $signed(shift_ext) >>> shamt;

    assign sign = add_sub[31];
    assign ovf  = (src1[31] != src2[31]) && (sign != src1[31]);
    assign lt   = sign ^ ovf;
    assign ltu  = add_sub[32];  // borrow out of the subtract

    always_comb begin
        case (ctrl.op)
            ALU_ADD_SUB: alu_out = add_sub[31:0];
            ALU_XOR:     alu_out = src1 ^ src2;
            ALU_OR:      alu_out = src1 | src2;
            ALU_AND:     alu_out = src1 & src2;
            ALU_SLL:     alu_out = src1 << shamt;
            ALU_SRL_SRA: alu_out = shift_wide[31:0];
            ALU_SLT:     alu_out = {31'b0, lt};
            ALU_SLTU:    alu_out = {31'b0, ltu};
            ALU_SRC2:    alu_out = src2;
            default:     alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result <= alu_out;
        end
    end

    // decoder must never hand over an undefined op
    a_op_defined: assert property (@(posedge clk) disable iff (reset)
        issue |-> ctrl.op inside {ALU_ADD_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
                                  ALU_SRL_SRA, ALU_SLT, ALU_SLTU, ALU_SRC2});

endmodule

// File: logic/rv32_decode.sv
`timescale 1ns/100ps

module rv32_decode (
    input  rv32_pkg::word_t     instr,
    output rv32_pkg::alu_ctrl_t ctrl,
    output rv32_pkg::word_t     imm,
    output logic                illegal
);
    import rv32_pkg::*;

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    logic [6:0] opcode;
    funct3_e    funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign funct3 = funct3_e'(instr[14:12]);
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // funct3 order differs from the alu op encoding
    function automatic alu_op_e op_from_funct3(input funct3_e f3);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = ALU_ADD_SUB;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = ALU_SRL_SRA;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD_SUB;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.op       = ALU_ADD_SUB;
        ctrl.sub_sra  = 1'b0;
        ctrl.src1_sel = SRC1_REG;
        ctrl.src2_sel = SRC2_REG;
        imm           = '0;
        illegal       = 1'b0;

        case (opcode)
            OPC_OP: begin
                ctrl.op = op_from_funct3(funct3);
                // 0x20 only selects SUB or SRA
                if (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)) begin
                    ctrl.sub_sra = 1'b1;
                end else if (funct7 != F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ctrl.op       = op_from_funct3(funct3);
                ctrl.src2_sel = SRC2_IMM;
                imm           = imm_i;
                // upper immediate bits are funct7 for shifts only
                if (funct3 == F3_SRL_SRA && funct7 == F7_ALT) begin
                    ctrl.sub_sra = 1'b1;
                end else if ((funct3 == F3_SLL || funct3 == F3_SRL_SRA) &&
                             funct7 != F7_BASE) begin
                    illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl.op       = ALU_SRC2;
                ctrl.src2_sel = SRC2_IMM;
                imm           = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.op       = ALU_ADD_SUB;
                ctrl.src1_sel = SRC1_PC;
                ctrl.src2_sel = SRC2_IMM;
                imm           = imm_u;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: logic/rv32_pkg.sv
`include "rv32_defines.svh"

package rv32_pkg;

    typedef logic [`RV32_XLEN-1:0] word_t;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD_SUB = 4'b0000,
        ALU_XOR     = 4'b0001,
        ALU_OR      = 4'b0010,
        ALU_AND     = 4'b0011,
        ALU_SLL     = 4'b0100,
        ALU_SRL_SRA = 4'b0101,
        ALU_SLT     = 4'b0110,
        ALU_SLTU    = 4'b0111,
        ALU_SRC2    = 4'b1000
    } alu_op_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic {
        SRC2_REG = 1'b0,
        SRC2_IMM = 1'b1
    } src2_sel_e;

    // major opcodes handled by the unit
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    typedef struct packed {
        alu_op_e   op;
        logic      sub_sra;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
    } alu_ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t rs1_value;
        word_t rs2_value;
        word_t imm;
    } issue_t;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic                        awvalid;
        logic [`RV32_AXI_ADDR_W-1:0] awaddr;
        logic                        wvalid;
        word_t                       wdata;
        logic [`RV32_XLEN/8-1:0]     wstrb;
        logic                        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic                        arvalid;
        logic [`RV32_AXI_ADDR_W-1:0] araddr;
        logic                        rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic       arready;
        logic       rvalid;
        word_t      rdata;
        logic [1:0] rresp;
    } axil_rd_rsp_t;

endpackage

// File: logic/rv32_defines.svh
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// datapath width, one machine word
`define RV32_XLEN 32

// AXI4-Lite address width seen by the register block
`define RV32_AXI_ADDR_W 8

// register map, byte offsets
`define RV32_REG_PC     8'h00
`define RV32_REG_RS1    8'h04
`define RV32_REG_RS2    8'h08

// writing INSTR launches the instruction
`define RV32_REG_INSTR  8'h0C

// read-only
`define RV32_REG_RESULT 8'h10

// read-only, bit 0 done, bit 1 illegal
`define RV32_REG_STATUS 8'h14

// status bit positions
`define RV32_STATUS_DONE    0
`define RV32_STATUS_ILLEGAL 1

`endif
